/* dv/chip_pad_assertions.sv */
// concurrent checks on the host handshake, power-on and reset state
// bound into chip_pad_top
`timescale 1ns/1ps
`default_nettype none

module chip_pad_assertions
  import pad_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  wire        por_done_i,
  input  wire        host_req_i,
  input  wire        host_ack_i,
  input  wire        bus_req_i,
  input  wire        bus_we_i,
  input  wire        bus_ack_i,
  input  wire        bus_from_sampler_i,
  input  gpio_vec_t  gpio_d2p_i,
  input  gpio_vec_t  gpio_en_i,
  input  wire        uart_tx_i,
  input  wire        uart_tx_en_i
);

  logic host_wr_seen_q;

  // a host write commits on the edge its ack rises
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      host_wr_seen_q <= 1'b0;
    end else if (bus_req_i && bus_we_i && !bus_from_sampler_i && !bus_ack_i) begin
      host_wr_seen_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // power-on and reset
  ////////////////////////////////////////////////////////////
  a_reset_state: assert property (@(posedge clk_aon)
    !rst_n_i |-> (!por_done_i && !host_ack_i && gpio_d2p_i == '0 && gpio_en_i == '0 &&
                  !uart_tx_i && !uart_tx_en_i))
    else $error("outputs not idle while reset is asserted");

  a_por_sticky: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    por_done_i |=> por_done_i)
    else $error("power-on done dropped after rising");

  a_no_ack_before_por: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    !por_done_i |-> !host_ack_i)
    else $error("host ack seen before power-on done");

  ////////////////////////////////////////////////////////////
  // host handshake
  ////////////////////////////////////////////////////////////
  // req is looked at on the edge that raised ack
  a_ack_needs_req: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    $rose(host_ack_i) |-> $past(host_req_i))
    else $error("host ack rose without a request");

  // ack low by the next cycle, inside the two cycle bound
  a_ack_drops: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    $fell(host_req_i) |=> !host_ack_i)
    else $error("host ack still high after request fell");

  a_enables_quiet: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    !host_wr_seen_q |-> (gpio_en_i == '0 && !uart_tx_en_i))
    else $error("output enable set before any host write");

endmodule

bind chip_pad_top chip_pad_assertions u_assertions (
  .clk_aon            (clk_aon),
  .rst_n_i            (rst_n_i),
  .por_done_i         (por_done_o),
  .host_req_i         (host_req_i),
  .host_ack_i         (host_ack_o),
  .bus_req_i          (bus_req),
  .bus_we_i           (bus_we),
  .bus_ack_i          (bus_ack),
  .bus_from_sampler_i (bus_from_sampler),
  .gpio_d2p_i         (cio_gpio_d2p_o),
  .gpio_en_i          (cio_gpio_en_d2p_o),
  .uart_tx_i          (cio_uart_tx_d2p_o),
  .uart_tx_en_i       (cio_uart_tx_en_d2p_o)
);

`default_nettype wire

/* dv/tb_chip_pad_top.sv */
// testbench for the pad wrapper: power-on timing, straps, pin layout
// host reads and writes over the shared pad register bus
`timescale 1ns/1ps
`default_nettype none

module tb_chip_pad_top
  import pad_pkg::*;
  import regbus_pkg::*;
();

  // roughly 600 cycles of traffic, about three times that as margin
  localparam int max_cycles = 2000;

  logic clk_aon;
  logic rst_n_i;
  gpio_vec_t cio_gpio_p2d_i;
  logic cio_uart_rx_p2d_i;
  logic host_req_i;
  logic host_we_i;
  reg_addr_t host_addr_i;
  reg_data_t host_wdata_i;
  gpio_vec_t cio_gpio_d2p_o;
  gpio_vec_t cio_gpio_en_d2p_o;
  gpio_vec_t cio_gpio_pull_en_o;
  gpio_vec_t cio_gpio_pull_select_o;
  logic cio_uart_tx_d2p_o;
  logic cio_uart_tx_en_d2p_o;
  logic host_ack_o;
  reg_data_t host_rdata_o;
  logic por_done_o;

  int check_cnt = 0;
  int err_cnt = 0;
  int cycle_cnt = 0;
  logic verdict_done = 1'b0;

  chip_pad_top uut (
    .clk_aon                (clk_aon),
    .rst_n_i                (rst_n_i),
    .cio_gpio_p2d_i         (cio_gpio_p2d_i),
    .cio_gpio_d2p_o         (cio_gpio_d2p_o),
    .cio_gpio_en_d2p_o      (cio_gpio_en_d2p_o),
    .cio_gpio_pull_en_o     (cio_gpio_pull_en_o),
    .cio_gpio_pull_select_o (cio_gpio_pull_select_o),
    .cio_uart_rx_p2d_i      (cio_uart_rx_p2d_i),
    .cio_uart_tx_d2p_o      (cio_uart_tx_d2p_o),
    .cio_uart_tx_en_d2p_o   (cio_uart_tx_en_d2p_o),
    .host_req_i             (host_req_i),
    .host_we_i              (host_we_i),
    .host_addr_i            (host_addr_i),
    .host_wdata_i           (host_wdata_i),
    .host_ack_o             (host_ack_o),
    .host_rdata_o           (host_rdata_o),
    .por_done_o             (por_done_o)
  );

  initial begin
    clk_aon = 1'b0;
    forever #2 clk_aon = ~clk_aon;
  end

  ////////////////////////////////////////////////////////////
  // expected pin layout
  ////////////////////////////////////////////////////////////
  // b and r pads on 13:0, sw straps on 24:22, tap1 on 27, tap0 on 30
  function automatic gpio_vec_t pins_of(input mio_vec_t v);
    gpio_vec_t p;
    p = '0;
    p[13:0] = v[13:0];
    p[24:22] = v[16:14];
    p[27] = v[18];
    p[30] = v[17];
    return p;
  endfunction

  function automatic mio_vec_t pads_of(input gpio_vec_t p, input logic rx);
    mio_vec_t v;
    v = '0;
    v[13:0] = p[13:0];
    v[16:14] = p[24:22];
    v[17] = p[30];
    v[18] = p[27];
    v[19] = rx;
    return v;
  endfunction

  function automatic logic [31:0] straps_of(input gpio_vec_t p);
    return {27'b0, p[27], p[30], p[24:22]};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // four-phase host port
  ////////////////////////////////////////////////////////////
  task automatic host_start(input logic we, input reg_addr_t addr, input reg_data_t wdata);
    host_we_i = we;
    host_addr_i = addr;
    host_wdata_i = wdata;
    host_req_i = 1'b1;
  endtask

  task automatic host_finish(output reg_data_t rdata);
    while (!host_ack_o) begin
      @(negedge clk_aon);
    end
    rdata = host_rdata_o;
    host_req_i = 1'b0;
    while (host_ack_o) begin
      @(negedge clk_aon);
    end
  endtask

  task automatic host_write(input reg_addr_t addr, input reg_data_t wdata);
    reg_data_t unused;
    host_start(1'b1, addr, wdata);
    host_finish(unused);
  endtask

  task automatic host_read(input reg_addr_t addr, output reg_data_t rdata);
    host_start(1'b0, addr, '0);
    host_finish(rdata);
  endtask

  task automatic readback_check(input reg_addr_t addr, input logic [31:0] keep_mask);
    reg_data_t rnd;
    reg_data_t rd;
    repeat (3) begin
      rnd = $urandom;
      host_write(addr, rnd);
      host_read(addr, rd);
      check("register readback", rd, rnd & keep_mask);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    reg_data_t rd;
    reg_data_t rnd;
    gpio_vec_t strap_pins;
    mio_vec_t v;
    rst_n_i = 1'b0;
    cio_gpio_p2d_i = '0;
    cio_uart_rx_p2d_i = 1'b0;
    host_req_i = 1'b0;
    host_we_i = 1'b0;
    host_addr_i = '0;
    host_wdata_i = '0;
    rnd = $urandom(39);
    strap_pins = $urandom;
    cio_gpio_p2d_i = strap_pins;
    repeat (2) @(negedge clk_aon);

    // host read of the strap register pending across power-on
    host_start(1'b0, reg_strap, '0);
    rst_n_i = 1'b1;
    for (int n = 1; n <= 20; n++) begin
      @(negedge clk_aon);
      check("power-on done", {31'b0, por_done_o}, (n >= 18) ? 32'd1 : 32'd0);
      if (!por_done_o) begin
        check("host ack before power-on", {31'b0, host_ack_o}, 32'd0);
      end
    end
    host_finish(rd);
    check("strap capture", rd, straps_of(strap_pins));
    host_write(reg_strap, ~rd);
    host_read(reg_strap, rd);
    check("strap after host write", rd, straps_of(strap_pins));

    for (int r = 0; r < 8; r++) begin
      rnd = $urandom;
      v = rnd[20:0];
      host_write(reg_out, rnd);
      check("gpio out pins", cio_gpio_d2p_o, pins_of(v));
      check("uart tx", {31'b0, cio_uart_tx_d2p_o}, {31'b0, v[20]});
      rnd = $urandom;
      v = rnd[20:0];
      host_write(reg_oe, rnd);
      check("gpio enable pins", cio_gpio_en_d2p_o, pins_of(v));
      check("uart tx enable", {31'b0, cio_uart_tx_en_d2p_o}, {31'b0, v[20]});
      rnd = $urandom;
      v = rnd[20:0];
      host_write(reg_pull_en, rnd);
      check("pull enable pins", cio_gpio_pull_en_o, pins_of(v));
      rnd = $urandom;
      v = rnd[20:0];
      host_write(reg_pull_sel, rnd);
      check("pull select pins", cio_gpio_pull_select_o, pins_of(v));
    end

    // inputs settle through the two flop synchronizer
    for (int r = 0; r < 8; r++) begin
      cio_gpio_p2d_i = $urandom;
      rnd = $urandom;
      cio_uart_rx_p2d_i = rnd[0];
      repeat (3) @(negedge clk_aon);
      host_read(reg_in, rd);
      check("pad inputs", rd, {11'b0, pads_of(cio_gpio_p2d_i, cio_uart_rx_p2d_i)});
    end

    readback_check(reg_out, 32'h001f_ffff);
    readback_check(reg_oe, 32'h001f_ffff);
    readback_check(reg_pull_en, 32'h001f_ffff);
    readback_check(reg_pull_sel, 32'h001f_ffff);
    readback_check(3'd6, 32'h0);
    readback_check(3'd7, 32'h0);
    host_read(reg_strap, rd);
    check("strap kept", rd, straps_of(strap_pins));

    report_counts();
    verdict_done = 1'b1;
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk_aon) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles && !verdict_done) begin
      $display("timeout: test sequence did not end within %0d cycles", max_cycles);
      report_counts();
      verdict_done = 1'b1;
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // run stopped early, for instance by a failing assertion
  final begin
    if (!verdict_done) begin
      $display("simulation stopped before the test sequence ended");
      report_counts();
      $display("*** TEST FAILED ***");
    end
  end

endmodule

`default_nettype wire

/* hw/chip_pad_top.sv */
// pad-facing chip wrapper: power-on, pad ring, pad registers
// strap sampler and host port on a shared register bus
`timescale 1ns/1ps
`default_nettype none

module chip_pad_top
  import pad_pkg::*;
  import regbus_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  gpio_vec_t  cio_gpio_p2d_i,
  output gpio_vec_t  cio_gpio_d2p_o,
  output gpio_vec_t  cio_gpio_en_d2p_o,
  output gpio_vec_t  cio_gpio_pull_en_o,
  output gpio_vec_t  cio_gpio_pull_select_o,
  input  wire        cio_uart_rx_p2d_i,
  output logic       cio_uart_tx_d2p_o,
  output logic       cio_uart_tx_en_d2p_o,
  input  wire        host_req_i,
  input  wire        host_we_i,
  input  reg_addr_t  host_addr_i,
  input  reg_data_t  host_wdata_i,
  output logic       host_ack_o,
  output reg_data_t  host_rdata_o,
  output logic       por_done_o
);

  // sampler side
  logic smp_req;
  logic smp_ack;
  reg_addr_t smp_addr;
  reg_data_t smp_wdata;

  // shared register bus
  logic bus_req;
  logic bus_we;
  logic bus_ack;
  logic bus_from_sampler;
  reg_addr_t bus_addr;
  reg_data_t bus_wdata;
  reg_data_t bus_rdata;

  // pad state
  mio_vec_t pad_out;
  mio_vec_t pad_oe;
  mio_vec_t pad_pull_en;
  mio_vec_t pad_pull_sel;
  mio_vec_t pad_in_sync;
  strap_t strap_sync;

  ////////////////////////////////////////////////////////////
  // power-on
  ////////////////////////////////////////////////////////////
  por_seq u_por_seq (
    .clk_aon    (clk_aon),
    .rst_n_i    (rst_n_i),
    .por_done_o (por_done_o)
  );

  ////////////////////////////////////////////////////////////
  // pads
  ////////////////////////////////////////////////////////////
  pad_ring u_pad_ring (
    .clk_aon                (clk_aon),
    .rst_n_i                (rst_n_i),
    .cio_gpio_p2d_i         (cio_gpio_p2d_i),
    .cio_uart_rx_p2d_i      (cio_uart_rx_p2d_i),
    .pad_out_i              (pad_out),
    .pad_oe_i               (pad_oe),
    .pad_pull_en_i          (pad_pull_en),
    .pad_pull_sel_i         (pad_pull_sel),
    .cio_gpio_d2p_o         (cio_gpio_d2p_o),
    .cio_gpio_en_d2p_o      (cio_gpio_en_d2p_o),
    .cio_gpio_pull_en_o     (cio_gpio_pull_en_o),
    .cio_gpio_pull_select_o (cio_gpio_pull_select_o),
    .cio_uart_tx_d2p_o      (cio_uart_tx_d2p_o),
    .cio_uart_tx_en_d2p_o   (cio_uart_tx_en_d2p_o),
    .pad_in_o               (pad_in_sync),
    .strap_o                (strap_sync)
  );

  pad_regs u_pad_regs (
    .clk_aon            (clk_aon),
    .rst_n_i            (rst_n_i),
    .bus_req_i          (bus_req),
    .bus_we_i           (bus_we),
    .bus_addr_i         (bus_addr),
    .bus_wdata_i        (bus_wdata),
    .bus_from_sampler_i (bus_from_sampler),
    .bus_ack_o          (bus_ack),
    .bus_rdata_o        (bus_rdata),
    .pad_in_i           (pad_in_sync),
    .pad_out_o          (pad_out),
    .pad_oe_o           (pad_oe),
    .pad_pull_en_o      (pad_pull_en),
    .pad_pull_sel_o     (pad_pull_sel)
  );

  ////////////////////////////////////////////////////////////
  // bus peers
  ////////////////////////////////////////////////////////////
  strap_sampler u_strap_sampler (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .strap_i     (strap_sync),
    .smp_ack_i   (smp_ack),
    .smp_req_o   (smp_req),
    .smp_addr_o  (smp_addr),
    .smp_wdata_o (smp_wdata)
  );

  pad_bus_arbiter u_pad_bus_arbiter (
    .clk_aon            (clk_aon),
    .rst_n_i            (rst_n_i),
    .por_done_i         (por_done_o),
    .host_req_i         (host_req_i),
    .host_we_i          (host_we_i),
    .host_addr_i        (host_addr_i),
    .host_wdata_i       (host_wdata_i),
    .host_ack_o         (host_ack_o),
    .host_rdata_o       (host_rdata_o),
    .smp_req_i          (smp_req),
    .smp_addr_i         (smp_addr),
    .smp_wdata_i        (smp_wdata),
    .smp_ack_o          (smp_ack),
    .bus_req_o          (bus_req),
    .bus_we_o           (bus_we),
    .bus_addr_o         (bus_addr),
    .bus_wdata_o        (bus_wdata),
    .bus_from_sampler_o (bus_from_sampler),
    .bus_ack_i          (bus_ack),
    .bus_rdata_i        (bus_rdata)
  );

endmodule

`default_nettype wire

/* hw/pad_bus_arbiter.sv */
// arbiter for the pad register bus, strap sampler over host
`timescale 1ns/1ps
`default_nettype none

module pad_bus_arbiter
  import regbus_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  wire        por_done_i,
  input  wire        host_req_i,
  input  wire        host_we_i,
  input  reg_addr_t  host_addr_i,
  input  reg_data_t  host_wdata_i,
  output logic       host_ack_o,
  output reg_data_t  host_rdata_o,
  input  wire        smp_req_i,
  input  reg_addr_t  smp_addr_i,
  input  reg_data_t  smp_wdata_i,
  output logic       smp_ack_o,
  output logic       bus_req_o,
  output logic       bus_we_o,
  output reg_addr_t  bus_addr_o,
  output reg_data_t  bus_wdata_o,
  output logic       bus_from_sampler_o,
  input  wire        bus_ack_i,
  input  reg_data_t  bus_rdata_i
);

  typedef enum logic [1:0] {grant_idle, grant_host, grant_smp} grant_t;

  grant_t grant_q;

  // grant holds until req and ack are both low
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_q <= grant_idle;
    end else begin
      unique case (grant_q)
        grant_idle: begin
          if (por_done_i && smp_req_i) begin
            grant_q <= grant_smp;
          end else if (por_done_i && host_req_i) begin
            grant_q <= grant_host;
          end
        end
        grant_host: begin
          if (!host_req_i && !bus_ack_i) begin
            grant_q <= grant_idle;
          end
        end
        grant_smp: begin
          if (!smp_req_i && !bus_ack_i) begin
            grant_q <= grant_idle;
          end
        end
        default: begin
          grant_q <= grant_idle;
        end
      endcase
    end
  end

  // route the bus to the owner, responses to the owner only
  always_comb begin
    bus_req_o = 1'b0;
    bus_we_o = host_we_i;
    bus_addr_o = host_addr_i;
    bus_wdata_o = host_wdata_i;
    bus_from_sampler_o = 1'b0;
    host_ack_o = 1'b0;
    host_rdata_o = '0;
    smp_ack_o = 1'b0;
    unique case (grant_q)
      grant_host: begin
        bus_req_o = host_req_i;
        host_ack_o = bus_ack_i;
        host_rdata_o = bus_rdata_i;
      end
      grant_smp: begin
        // sampler only writes
        bus_req_o = smp_req_i;
        bus_we_o = 1'b1;
        bus_addr_o = smp_addr_i;
        bus_wdata_o = smp_wdata_i;
        bus_from_sampler_o = 1'b1;
        smp_ack_o = bus_ack_i;
      end
      default: begin
        bus_req_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/pad_pkg.sv */
// pad count, pad indices and pin positions of the pad ring
// pad and pin vector types
`default_nettype none

package pad_pkg;

  // multiplexed pads
  localparam int n_mio_pads = 21;
  localparam int n_gpio_group = 7;
  localparam int n_sw_straps = 3;
  localparam int strap_w = 5;

  typedef logic [n_mio_pads-1:0] mio_vec_t;
  typedef logic [31:0] gpio_vec_t;

  // sw straps in 2:0, tap strap 0 in 3, tap strap 1 in 4
  typedef logic [strap_w-1:0] strap_t;

  ////////////////////////////////////////////////////////////
  // pad indices
  ////////////////////////////////////////////////////////////
  localparam int mio_gpio_b_lo = 0;
  localparam int mio_gpio_r_lo = 7;
  localparam int mio_sw_strap_lo = 14;
  localparam int mio_tap_strap0 = 17;
  localparam int mio_tap_strap1 = 18;
  localparam int mio_uart_rx = 19;
  localparam int mio_uart_tx = 20;

  ////////////////////////////////////////////////////////////
  // positions on the gpio pin vector
  ////////////////////////////////////////////////////////////
  localparam int pin_gpio_b_lo = 0;
  localparam int pin_gpio_r_lo = 7;
  localparam int pin_sw_strap_lo = 22;
  localparam int pin_tap_strap1 = 27;
  localparam int pin_tap_strap0 = 30;

endpackage

`default_nettype wire

/* hw/pad_regs.sv */
// pad state registers: output, enable, pull, strap
// register decode and four-phase ack
`timescale 1ns/1ps
`default_nettype none

module pad_regs
  import pad_pkg::*;
  import regbus_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  wire        bus_req_i,
  input  wire        bus_we_i,
  input  reg_addr_t  bus_addr_i,
  input  reg_data_t  bus_wdata_i,
  input  wire        bus_from_sampler_i,
  output logic       bus_ack_o,
  output reg_data_t  bus_rdata_o,
  input  mio_vec_t   pad_in_i,
  output mio_vec_t   pad_out_o,
  output mio_vec_t   pad_oe_o,
  output mio_vec_t   pad_pull_en_o,
  output mio_vec_t   pad_pull_sel_o
);

  mio_vec_t out_q;
  mio_vec_t oe_q;
  mio_vec_t pull_en_q;
  mio_vec_t pull_sel_q;
  strap_t strap_q;
  logic ack_q;
  logic wr_en;

  // one write per request, on the edge that raises ack
  assign wr_en = bus_req_i && !ack_q && bus_we_i;

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      out_q <= '0;
      oe_q <= '0;
      pull_en_q <= '0;
      pull_sel_q <= '0;
      strap_q <= '0;
    end else begin
      // ack follows req one cycle later, both edges
      ack_q <= bus_req_i;
      if (wr_en) begin
        unique case (bus_addr_i)
          reg_out:      out_q <= bus_wdata_i[n_mio_pads-1:0];
          reg_oe:       oe_q <= bus_wdata_i[n_mio_pads-1:0];
          reg_pull_en:  pull_en_q <= bus_wdata_i[n_mio_pads-1:0];
          reg_pull_sel: pull_sel_q <= bus_wdata_i[n_mio_pads-1:0];
          reg_strap: begin
            if (bus_from_sampler_i) begin
              strap_q <= bus_wdata_i[strap_w-1:0];
            end
          end
          default: begin
            // reg_in and unused addresses
            out_q <= out_q;
          end
        endcase
      end
    end
  end

  // read mux, held by the stable address while ack is high
  always_comb begin
    bus_rdata_o = '0;
    unique case (bus_addr_i)
      reg_out:      bus_rdata_o[n_mio_pads-1:0] = out_q;
      reg_oe:       bus_rdata_o[n_mio_pads-1:0] = oe_q;
      reg_pull_en:  bus_rdata_o[n_mio_pads-1:0] = pull_en_q;
      reg_pull_sel: bus_rdata_o[n_mio_pads-1:0] = pull_sel_q;
      reg_in:       bus_rdata_o[n_mio_pads-1:0] = pad_in_i;
      reg_strap:    bus_rdata_o[strap_w-1:0] = strap_q;
      default:      bus_rdata_o = '0;
    endcase
  end

  assign bus_ack_o = ack_q;
  assign pad_out_o = out_q;
  assign pad_oe_o = oe_q;
  assign pad_pull_en_o = pull_en_q;
  assign pad_pull_sel_o = pull_sel_q;

endmodule

`default_nettype wire

/* hw/pad_ring.sv */
// pad ring: input synchronizers, gpio and uart pin layout
`timescale 1ns/1ps
`default_nettype none

module pad_ring
  import pad_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  gpio_vec_t  cio_gpio_p2d_i,
  input  wire        cio_uart_rx_p2d_i,
  input  mio_vec_t   pad_out_i,
  input  mio_vec_t   pad_oe_i,
  input  mio_vec_t   pad_pull_en_i,
  input  mio_vec_t   pad_pull_sel_i,
  output gpio_vec_t  cio_gpio_d2p_o,
  output gpio_vec_t  cio_gpio_en_d2p_o,
  output gpio_vec_t  cio_gpio_pull_en_o,
  output gpio_vec_t  cio_gpio_pull_select_o,
  output logic       cio_uart_tx_d2p_o,
  output logic       cio_uart_tx_en_d2p_o,
  output mio_vec_t   pad_in_o,
  output strap_t     strap_o
);

  mio_vec_t pad_raw;
  mio_vec_t sync1_q;
  mio_vec_t sync2_q;

  // pads onto pins, unused pins stay zero
  function automatic gpio_vec_t scatter(input mio_vec_t v);
    gpio_vec_t p;
    p = '0;
    p[pin_gpio_b_lo +: n_gpio_group] = v[mio_gpio_b_lo +: n_gpio_group];
    p[pin_gpio_r_lo +: n_gpio_group] = v[mio_gpio_r_lo +: n_gpio_group];
    p[pin_sw_strap_lo +: n_sw_straps] = v[mio_sw_strap_lo +: n_sw_straps];
    p[pin_tap_strap1] = v[mio_tap_strap1];
    p[pin_tap_strap0] = v[mio_tap_strap0];
    return p;
  endfunction

  // pins into pads, the tx pad has no input
  function automatic mio_vec_t gather(input gpio_vec_t p, input logic rx);
    mio_vec_t v;
    v = '0;
    v[mio_gpio_b_lo +: n_gpio_group] = p[pin_gpio_b_lo +: n_gpio_group];
    v[mio_gpio_r_lo +: n_gpio_group] = p[pin_gpio_r_lo +: n_gpio_group];
    v[mio_sw_strap_lo +: n_sw_straps] = p[pin_sw_strap_lo +: n_sw_straps];
    v[mio_tap_strap1] = p[pin_tap_strap1];
    v[mio_tap_strap0] = p[pin_tap_strap0];
    v[mio_uart_rx] = rx;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // inputs
  ////////////////////////////////////////////////////////////
  assign pad_raw = gather(cio_gpio_p2d_i, cio_uart_rx_p2d_i);

  // two flop synchronizer
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= pad_raw;
      sync2_q <= sync1_q;
    end
  end

  assign pad_in_o = sync2_q;
  assign strap_o = {sync2_q[mio_tap_strap1], sync2_q[mio_tap_strap0],
                    sync2_q[mio_sw_strap_lo +: n_sw_straps]};

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////
  assign cio_gpio_d2p_o = scatter(pad_out_i);
  assign cio_gpio_en_d2p_o = scatter(pad_oe_i);
  // pull vectors keep the same ordering as the data pins
  assign cio_gpio_pull_en_o = scatter(pad_pull_en_i);
  assign cio_gpio_pull_select_o = scatter(pad_pull_sel_i);

  assign cio_uart_tx_d2p_o = pad_out_i[mio_uart_tx];
  assign cio_uart_tx_en_d2p_o = pad_oe_i[mio_uart_tx];

endmodule

`default_nettype wire

/* hw/por_seq.sv */
// artificial supply glitch and power-ok filter
`timescale 1ns/1ps
`default_nettype none

module por_seq
  import regbus_pkg::*;
(
  input  wire  clk_aon,
  input  wire  rst_n_i,
  output logic por_done_o
);

  supp_cnt_t supp_cnt_q;
  supp_cnt_t filt_cnt_q;
  por_state_t state_q;
  logic supply;

  // count up until saturation
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      supp_cnt_q <= '0;
    end else if (supp_cnt_q != supp_cnt_max) begin
      supp_cnt_q <= supp_cnt_q + 1'b1;
    end
  end

  // rise, drop, rise again
  assign supply = ((supp_cnt_q >= supp_rise_cnt) && (supp_cnt_q < supp_drop_cnt)) ||
                  (supp_cnt_q >= supp_rerise_cnt);

  ////////////////////////////////////////////////////////////
  // power-ok filter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= por_wait_supply;
      filt_cnt_q <= '0;
    end else begin
      unique case (state_q)
        por_wait_supply: begin
          if (supply) begin
            state_q <= por_filter;
            filt_cnt_q <= 4'd1;
          end
        end
        por_filter: begin
          if (!supply) begin
            // glitch, start over
            state_q <= por_wait_supply;
            filt_cnt_q <= '0;
          end else if (filt_cnt_q == por_filter_cycles - 1'b1) begin
            state_q <= por_done;
          end else begin
            filt_cnt_q <= filt_cnt_q + 1'b1;
          end
        end
        por_done: begin
          state_q <= por_done;
        end
        default: begin
          state_q <= por_wait_supply;
        end
      endcase
    end
  end

  assign por_done_o = (state_q == por_done);

endmodule

`default_nettype wire

/* hw/regbus_pkg.sv */
// pad register bus types and register map
// power-on sequence constants and state type
`default_nettype none

package regbus_pkg;

  typedef logic [2:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // register map, 6 and 7 unused
  localparam reg_addr_t reg_out = 3'd0;
  localparam reg_addr_t reg_oe = 3'd1;
  localparam reg_addr_t reg_pull_en = 3'd2;
  localparam reg_addr_t reg_pull_sel = 3'd3;
  localparam reg_addr_t reg_in = 3'd4;
  localparam reg_addr_t reg_strap = 3'd5;

  ////////////////////////////////////////////////////////////
  // power-on sequence
  ////////////////////////////////////////////////////////////
  typedef logic [3:0] supp_cnt_t;

  localparam supp_cnt_t supp_rise_cnt = 4'd4;
  localparam supp_cnt_t supp_drop_cnt = 4'd8;
  localparam supp_cnt_t supp_rerise_cnt = 4'd12;
  localparam supp_cnt_t supp_cnt_max = 4'd15;
  localparam supp_cnt_t por_filter_cycles = 4'd6;

  typedef enum logic [1:0] {por_wait_supply, por_filter, por_done} por_state_t;

endpackage

`default_nettype wire

/* hw/strap_sampler.sv */
// one-shot strap capture into the strap register
`timescale 1ns/1ps
`default_nettype none

module strap_sampler
  import pad_pkg::*;
  import regbus_pkg::*;
(
  input  wire        clk_aon,
  input  wire        rst_n_i,
  input  strap_t     strap_i,
  input  wire        smp_ack_i,
  output logic       smp_req_o,
  output reg_addr_t  smp_addr_o,
  output reg_data_t  smp_wdata_o
);

  logic done_q;
  strap_t wdata_q;

  // request from reset until the first ack
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (smp_ack_i) begin
      done_q <= 1'b1;
    end
  end

  // track the straps until the write is taken
  always_ff @(posedge clk_aon) begin
    if (!done_q && !smp_ack_i) begin
      wdata_q <= strap_i;
    end
  end

  assign smp_req_o = !done_q;
  assign smp_addr_o = reg_strap;

  always_comb begin
    smp_wdata_o = '0;
    smp_wdata_o[strap_w-1:0] = wdata_q;
  end

endmodule

`default_nettype wire

/* list.f */
hw/pad_pkg.sv
hw/regbus_pkg.sv
hw/por_seq.sv
hw/pad_ring.sv
hw/pad_bus_arbiter.sv
hw/pad_regs.sv
hw/strap_sampler.sv
hw/chip_pad_top.sv
dv/chip_pad_assertions.sv
dv/tb_chip_pad_top.sv

/* run.sh */
#!/bin/sh
# build and run the pad wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_chip_pad_top -f list.f -o tb_sim
out=$(./obj_dir/tb_sim 2>&1 || true)
echo "$out"
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
